//--- cacheArrays.sv
module cacheArrays import cachePkg::*; (
	input logic clk,
	input logic reset,
	input logic [indexWidth-1:0] index,
	output lookupT lookup,
	output lineT readLine,
	input logic rdWay,
	input logic lineWe,
	input logic wordWe,
	input logic wrWay,
	input logic [indexWidth-1:0] wrIndex,
	input logic [tagWidth-1:0] wrTag,
	input lineT wrLine,
	input wordT wrWord,
	input logic [wordSelWidth-1:0] wrOffset,
	input logic setDirty,
	input logic touchWay,
	input logic touch
);

	logic [tagWidth-1:0] tags [numWays][numSets];
	lineT data [numWays][numSets];
	wayStateT states [numWays][numSets];
	logic [numSets-1:0] lru;

	// async read-out of the addressed set
	always_comb begin
		for (int w = 0; w < numWays; w++) begin
			lookup.tag[w] = tags[w][index];
			lookup.state[w] = states[w][index];
		end
		lookup.lru = lru[index];
	end

	assign readLine = data[rdWay][index];

	always_ff @(posedge clk) begin
		if (lineWe) begin
			tags[wrWay][wrIndex] <= wrTag;
			data[wrWay][wrIndex] <= wrLine;
		end else if (wordWe) begin
			data[wrWay][wrIndex][wrOffset] <= wrWord;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int w = 0; w < numWays; w++) begin
				for (int s = 0; s < numSets; s++) begin
					states[w][s] <= '0;
				end
			end
			lru <= '0;
		end else begin
			if (lineWe) begin
				states[wrWay][wrIndex] <= '{valid: 1'b1, dirty: 1'b0}; // fresh line is clean
			end else if (wordWe && setDirty) begin
				states[wrWay][wrIndex].dirty <= 1'b1;
			end
			if (touch)
				lru[wrIndex] <= ~touchWay; // other way becomes lru
		end
	end

endmodule

//--- cacheCtrl.sv
module cacheCtrl import cachePkg::*; (
	input logic clk,
	input logic reset,
	input logic cpuReq,
	input cpuReqT cpuReqData,
	output logic cpuAck,
	output cpuRespT cpuResp,
	output logic [indexWidth-1:0] index,
	input lookupT lookup,
	input lineT readLine,
	output logic rdWay,
	output logic lineWe,
	output logic wordWe,
	output logic wrWay,
	output logic [indexWidth-1:0] wrIndex,
	output logic [tagWidth-1:0] wrTag,
	output lineT wrLine,
	output wordT wrWord,
	output logic [wordSelWidth-1:0] wrOffset,
	output logic setDirty,
	output logic touchWay,
	output logic touch,
	output logic fillReq,
	output logic [addrWidth-1:0] fillAddr,
	input logic fillAck,
	input lineT fillLine,
	output logic wbReq,
	output memReqT wbData,
	input logic wbAck,
	input logic wbBusy
);

	typedef enum logic [1:0] {sIdle, sMiss, sFill, sRespond} ctrlStateT;

	ctrlStateT state;
	logic missFlag; // current access started as a miss
	logic victimWay;
	logic [tagWidth-1:0] reqTag;
	logic [indexWidth-1:0] reqIndex;
	logic [wordSelWidth-1:0] reqWord;
	logic hit0, hit1, hit, hitWay;
	logic victim, needWb, done;

	assign reqTag = cpuReqData.addr[addrWidth-1 -: tagWidth];
	assign reqIndex = cpuReqData.addr[offsetWidth +: indexWidth];
	assign reqWord = cpuReqData.addr[offsetWidth-1 -: wordSelWidth];

	// --------------------
	// lookup
	assign hit0 = lookup.state[0].valid && (lookup.tag[0] == reqTag);
	assign hit1 = lookup.state[1].valid && (lookup.tag[1] == reqTag);
	assign hit = hit0 || hit1;
	assign hitWay = hit1;

	// invalid way first, else lru
	assign victim = !lookup.state[0].valid ? 1'b0 :
		!lookup.state[1].valid ? 1'b1 : lookup.lru;
	assign needWb = lookup.state[victimWay].valid && lookup.state[victimWay].dirty;
	assign done = (state == sIdle) && cpuReq && hit;

	// --------------------
	// array side
	assign index = reqIndex;
	assign wrIndex = reqIndex;
	assign rdWay = (state == sIdle) ? hitWay : victimWay;
	assign wrWay = (state == sFill) ? victimWay : hitWay;
	assign wrTag = reqTag;
	assign wrLine = fillLine;
	assign wrWord = cpuReqData.wdata;
	assign wrOffset = reqWord;
	assign lineWe = (state == sFill) && fillReq && fillAck;
	assign wordWe = done && cpuReqData.write;
	assign setDirty = cpuReqData.write;
	assign touch = done;
	assign touchWay = hitWay;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= sIdle;
			cpuAck <= 1'b0;
			fillReq <= 1'b0;
			wbReq <= 1'b0;
			missFlag <= 1'b0;
		end else begin
			case (state)
				sIdle: begin
					if (done) begin
						cpuAck <= 1'b1;
						cpuResp.rdata <= readLine[reqWord];
						cpuResp.hit <= !missFlag;
						missFlag <= 1'b0;
						state <= sRespond;
					end else if (cpuReq) begin
						victimWay <= victim;
						missFlag <= 1'b1;
						state <= sMiss;
					end
				end
				sMiss: begin
					// older store still running, hold off the next one
					if (!(needWb && wbBusy)) begin
						fillReq <= 1'b1;
						fillAddr <= {reqTag, reqIndex, {offsetWidth{1'b0}}};
						if (needWb) begin
							wbReq <= 1'b1;
							wbData.write <= 1'b1;
							wbData.lineAddr <= {lookup.tag[victimWay], reqIndex,
								{offsetWidth{1'b0}}};
							wbData.line <= readLine;
						end
						state <= sFill;
					end
				end
				sFill: begin
					if (wbReq && wbAck)
						wbReq <= 1'b0;
					if (fillReq && fillAck)
						fillReq <= 1'b0; // line installed this cycle
					if (!wbReq && !fillReq && !wbAck && !fillAck)
						state <= sIdle; // retry now hits
				end
				sRespond: begin
					if (!cpuReq) begin
						cpuAck <= 1'b0;
						state <= sIdle;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

endmodule

//--- cachePkg.sv
package cachePkg;

	// geometry
	localparam int addrWidth = 32;
	localparam int wordWidth = 32;
	localparam int wordsPerLine = 4;
	localparam int numSets = 16;
	localparam int numWays = 2;
	localparam int offsetWidth = 4; // byte offset in a line
	localparam int indexWidth = 4;
	localparam int tagWidth = addrWidth - indexWidth - offsetWidth;
	localparam int wordSelWidth = $clog2(wordsPerLine);

	typedef logic [wordWidth-1:0] wordT;
	typedef wordT [wordsPerLine-1:0] lineT;

	// --------------------
	// cpu side
	typedef struct packed {
		logic write;
		logic [addrWidth-1:0] addr;
		wordT wdata;
	} cpuReqT;

	typedef struct packed {
		wordT rdata;
		logic hit;
	} cpuRespT;

	// --------------------
	// memory side, one whole line per transaction
	typedef struct packed {
		logic write;
		logic [addrWidth-1:0] lineAddr;
		lineT line; // store data only
	} memReqT;

	typedef struct packed {
		logic valid;
		logic dirty;
	} wayStateT;

	typedef struct packed {
		logic [numWays-1:0][tagWidth-1:0] tag;
		wayStateT [numWays-1:0] state;
		logic lru; // least recently used way
	} lookupT;

endpackage

//--- cacheTop.sv
module cacheTop import cachePkg::*; (
	input logic clk,
	input logic reset,
	input logic cpuReq,
	input cpuReqT cpuReqData,
	output logic cpuAck,
	output cpuRespT cpuResp,
	output logic memReq,
	output memReqT memReqData,
	input logic memAck,
	input lineT memRdata
);

	logic [indexWidth-1:0] index, wrIndex;
	lookupT lookup;
	lineT readLine, wrLine, fillLine;
	logic rdWay, lineWe, wordWe, wrWay, setDirty, touchWay, touch;
	logic [tagWidth-1:0] wrTag;
	wordT wrWord;
	logic [wordSelWidth-1:0] wrOffset;
	logic fillReq, fillAck, wbReq, wbAck, wbBusy;
	logic [addrWidth-1:0] fillAddr;
	memReqT wbData, wbMemData, fillMemData;
	logic wbMemReq, wbMemAck, fillMemReq, fillMemAck;

	cacheArrays arraysInst (.clk, .reset, .index, .lookup, .readLine, .rdWay, .lineWe,
		.wordWe, .wrWay, .wrIndex, .wrTag, .wrLine, .wrWord, .wrOffset, .setDirty,
		.touchWay, .touch);

	cacheCtrl ctrlInst (.clk, .reset, .cpuReq, .cpuReqData, .cpuAck, .cpuResp, .index,
		.lookup, .readLine, .rdWay, .lineWe, .wordWe, .wrWay, .wrIndex, .wrTag, .wrLine,
		.wrWord, .wrOffset, .setDirty, .touchWay, .touch, .fillReq, .fillAddr, .fillAck,
		.fillLine, .wbReq, .wbData, .wbAck, .wbBusy);

	lineFill fillInst (.clk, .reset, .fillReq, .fillAddr, .fillAck, .fillLine,
		.memReqOut(fillMemReq), .memReqData(fillMemData), .memAck(fillMemAck), .memRdata);

	lineWriteback wbInst (.clk, .reset, .wbReq, .wbData, .wbAck, .wbBusy,
		.memReqOut(wbMemReq), .memReqData(wbMemData), .memAck(wbMemAck));

	memArbiter arbInst (.clk, .reset, .wbMemReq, .wbMemData, .wbMemAck, .fillMemReq,
		.fillMemData, .fillMemAck, .memReq, .memReqData, .memAck);

endmodule

//--- lineFill.sv
module lineFill import cachePkg::*; (
	input logic clk,
	input logic reset,
	input logic fillReq,
	input logic [addrWidth-1:0] fillAddr,
	output logic fillAck,
	output lineT fillLine,
	output logic memReqOut,
	output memReqT memReqData,
	input logic memAck,
	input lineT memRdata
);

	typedef enum logic [1:0] {sIdle, sMem, sDrain, sAck} fillStateT;

	fillStateT state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= sIdle;
			fillAck <= 1'b0;
			memReqOut <= 1'b0;
		end else begin
			case (state)
				sIdle: if (fillReq) begin
					memReqOut <= 1'b1;
					memReqData.write <= 1'b0;
					memReqData.lineAddr <= fillAddr;
					memReqData.line <= '0;
					state <= sMem;
				end
				sMem: if (memAck) begin
					fillLine <= memRdata;
					memReqOut <= 1'b0;
					state <= sDrain;
				end
				sDrain: if (!memAck) begin // memory side closed
					fillAck <= 1'b1;
					state <= sAck;
				end
				sAck: if (!fillReq) begin
					fillAck <= 1'b0;
					state <= sIdle;
				end
				default: state <= sIdle;
			endcase
		end
	end

endmodule

//--- lineWriteback.sv
module lineWriteback import cachePkg::*; (
	input logic clk,
	input logic reset,
	input logic wbReq,
	input memReqT wbData,
	output logic wbAck,
	output logic wbBusy,
	output logic memReqOut,
	output memReqT memReqData,
	input logic memAck
);

	always_ff @(posedge clk) begin
		if (reset) begin
			wbAck <= 1'b0;
			wbBusy <= 1'b0;
			memReqOut <= 1'b0;
		end else begin
			// controller side, ack as soon as the line is held here
			if (wbReq && !wbAck && !wbBusy) begin
				memReqData <= wbData;
				wbAck <= 1'b1;
				wbBusy <= 1'b1;
				memReqOut <= 1'b1;
			end else begin
				if (!wbReq)
					wbAck <= 1'b0;
				if (memReqOut && memAck)
					memReqOut <= 1'b0;
				if (wbBusy && !memReqOut && !memAck)
					wbBusy <= 1'b0; // store handshake finished
			end
		end
	end

endmodule

//--- list.f
cachePkg.sv
cacheArrays.sv
cacheCtrl.sv
lineFill.sv
lineWriteback.sv
memArbiter.sv
cacheTop.sv
tbMemory.sv
tbCache.sv

//--- memArbiter.sv
module memArbiter import cachePkg::*; (
	input logic clk,
	input logic reset,
	input logic wbMemReq,
	input memReqT wbMemData,
	output logic wbMemAck,
	input logic fillMemReq,
	input memReqT fillMemData,
	output logic fillMemAck,
	output logic memReq,
	output memReqT memReqData,
	input logic memAck
);

	logic busy;
	logic ownerWb; // 1 = writeback holds the port
	logic ownerReq;

	assign ownerReq = ownerWb ? wbMemReq : fillMemReq;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			ownerWb <= 1'b0;
		end else if (!busy) begin
			if (wbMemReq) begin
				busy <= 1'b1;
				ownerWb <= 1'b1;
			end else if (fillMemReq) begin
				busy <= 1'b1;
				ownerWb <= 1'b0;
			end
		end else if (!ownerReq && !memAck) begin
			busy <= 1'b0; // four-phase cycle complete
		end
	end

	// --------------------
	// routing
	assign memReq = busy && ownerReq;
	assign memReqData = ownerWb ? wbMemData : fillMemData;
	assign wbMemAck = busy && ownerWb && memAck;
	assign fillMemAck = busy && !ownerWb && memAck;

endmodule

//--- tbCache.sv
module tbCache import cachePkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int memWords = 1024;
	// roughly 25 accesses of at most 35 cycles each
	localparam int timeoutCycles = 2000;

	logic clk;
	logic reset;
	logic cpuReq;
	cpuReqT cpuReqData;
	logic cpuAck;
	cpuRespT cpuResp;
	logic memReq;
	memReqT memReqData;
	logic memAck;
	lineT memRdata;
	int storeCount;
	int cycles = 0;

	// reference model of the cache and of memory
	logic [tagWidth-1:0] refTag [numSets][numWays];
	bit refValid [numSets][numWays];
	bit refDirty [numSets][numWays];
	lineT refData [numSets][numWays];
	bit refLru [numSets];
	wordT refMem [memWords];

	cacheTop cacheTop_inst (.clk, .reset, .cpuReq, .cpuReqData, .cpuAck, .cpuResp, .memReq,
		.memReqData, .memAck, .memRdata);

	tbMemory #(.memWords(memWords)) memInst (.clk, .reset, .memReq, .memReqData, .memAck,
		.memRdata, .storeCount);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeoutCycles) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("tests failed");
			$fatal(1);
		end
	end

	task automatic checkEq(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// --------------------
	// reference model
	task automatic modelAccess(input logic write, input logic [31:0] addr, input wordT wdata,
			output wordT rdata, output bit hit, output bit wroteBack);
		logic [tagWidth-1:0] tag;
		int set;
		int word;
		int way;
		int base;
		tag = addr[addrWidth-1 -: tagWidth];
		set = addr[offsetWidth +: indexWidth];
		word = addr[3:2];
		hit = 0;
		wroteBack = 0;
		way = 0;
		for (int w = 0; w < numWays; w++) begin
			if (refValid[set][w] && refTag[set][w] == tag) begin
				hit = 1;
				way = w;
			end
		end
		if (!hit) begin
			way = !refValid[set][0] ? 0 : !refValid[set][1] ? 1 : refLru[set];
			if (refValid[set][way] && refDirty[set][way]) begin
				base = {refTag[set][way], addr[offsetWidth +: indexWidth], 2'b00};
				for (int w = 0; w < wordsPerLine; w++)
					refMem[base + w] = refData[set][way][w];
				wroteBack = 1;
			end
			base = {addr[addrWidth-1:offsetWidth], 2'b00};
			for (int w = 0; w < wordsPerLine; w++)
				refData[set][way][w] = refMem[base + w];
			refTag[set][way] = tag;
			refValid[set][way] = 1;
			refDirty[set][way] = 0;
		end
		rdata = refData[set][way][word];
		if (write) begin
			refData[set][way][word] = wdata;
			refDirty[set][way] = 1;
		end
		refLru[set] = (way == 0); // other way is now lru
	endtask

	// --------------------
	// cpu handshake driven 1 ns after a rising edge
	task automatic cpuAccess(input logic write, input logic [31:0] addr, input wordT wdata,
			output cpuRespT resp, output int latency);
		int releaseCycles;
		cpuReqData.write = write;
		cpuReqData.addr = addr;
		cpuReqData.wdata = wdata;
		cpuReq = 1'b1;
		latency = 0;
		do begin
			@(posedge clk);
			#1;
			latency++;
		end while (!cpuAck);
		resp = cpuResp;
		cpuReq = 1'b0;
		releaseCycles = 0;
		do begin
			@(posedge clk);
			#1;
			releaseCycles++;
		end while (cpuAck);
		checkEq("cpuAck release cycles", 1, releaseCycles);
	endtask

	task automatic checkedAccess(input logic write, input logic [31:0] addr, input wordT wdata,
			input bit wantHit);
		wordT expData;
		bit expHit;
		bit expWb;
		cpuRespT resp;
		int latency;
		int storesBefore;
		storesBefore = storeCount;
		modelAccess(write, addr, wdata, expData, expHit, expWb);
		assert (expHit == wantHit) else begin
			$display("reference model and test disagree on hit at address %h", addr);
			$display("tests failed");
			$fatal(1);
		end
		cpuAccess(write, addr, wdata, resp, latency);
		checkEq("cpuResp.hit", expHit, resp.hit);
		if (!write)
			checkEq("cpuResp.rdata", expData, resp.rdata);
		if (expHit)
			checkEq("cpuAck latency", 1, latency);
		checkEq("storeCount", storesBefore + expWb, storeCount);
		if (expWb) begin
			for (int i = 0; i < memWords; i++)
				checkEq($sformatf("mem[%0d]", i), refMem[i], memInst.mem[i]);
		end
	endtask

	// --------------------
	// directed tests
	task automatic resetValues();
		checkEq("cpuAck", 0, cpuAck);
		checkEq("memReq", 0, memReq);
	endtask

	task automatic coldRead();
		checkedAccess(0, 32'h000, '0, 0);
		checkedAccess(0, 32'h004, '0, 1); // same line
	endtask

	task automatic writeHit();
		checkedAccess(1, 32'h008, 32'hc0de_0008, 1);
		checkedAccess(0, 32'h008, '0, 1);
	endtask

	task automatic lruOrder();
		checkedAccess(0, 32'h010, '0, 0); // set 1 gets A B C
		checkedAccess(0, 32'h110, '0, 0);
		checkedAccess(0, 32'h210, '0, 0); // A out
		checkedAccess(0, 32'h010, '0, 0); // B out
		checkedAccess(0, 32'h210, '0, 1);
		checkedAccess(0, 32'h020, '0, 0); // set 2 with A re-read after B
		checkedAccess(0, 32'h120, '0, 0);
		checkedAccess(0, 32'h020, '0, 1);
		checkedAccess(0, 32'h220, '0, 0); // B out
		checkedAccess(0, 32'h020, '0, 1);
		checkedAccess(0, 32'h120, '0, 0);
	endtask

	task automatic dirtyEvict();
		checkedAccess(1, 32'h034, 32'hd1e7_0034, 0);
		checkedAccess(0, 32'h134, '0, 0);
		checkedAccess(0, 32'h234, '0, 0); // dirty line goes back
		checkEq("mem[13]", 32'hd1e7_0034, memInst.mem[32'h034 >> 2]);
		checkedAccess(0, 32'h334, '0, 0); // clean victim so no store
	endtask

	task automatic writeMiss();
		checkedAccess(1, 32'h048, 32'h0b5e_0048, 0);
		checkedAccess(0, 32'h048, '0, 1);
		checkedAccess(0, 32'h040, '0, 1);
		checkedAccess(0, 32'h044, '0, 1);
		checkedAccess(0, 32'h04c, '0, 1);
	endtask

	initial begin
		reset = 1'b1;
		cpuReq = 1'b0;
		cpuReqData = '0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int i = 0; i < memWords; i++)
			refMem[i] = memInst.shadow[i];
		resetValues();
		coldRead();
		writeHit();
		lruOrder();
		dirtyEvict();
		writeMiss();
		$display("all tests passed");
		$finish;
	end

endmodule

//--- tbMemory.sv
module tbMemory import cachePkg::*; #(
	parameter int memWords = 1024
) (
	input logic clk,
	input logic reset,
	input logic memReq,
	input memReqT memReqData,
	output logic memAck = 1'b0,
	output lineT memRdata = '0,
	output int storeCount
);

	timeunit 1ns;
	timeprecision 100ps;

	wordT mem [memWords];
	wordT shadow [memWords]; // contents at time zero
	integer seed = 32'h5f90_9d4a;
	logic pending;
	int waitCycles;
	memReqT held;
	int base;

	initial begin
		for (int i = 0; i < memWords; i++) begin
			mem[i] = $random(seed) ^ (i << 2); // mixed with the byte address
			shadow[i] = mem[i];
		end
	end

	// --------------------
	// four-phase responder with 1 to 4 cycles of latency
	always @(posedge clk) begin
		if (reset) begin
			memAck <= 1'b0;
			pending <= 1'b0;
			storeCount <= 0;
		end else if (pending) begin
			if (waitCycles > 1) begin
				waitCycles <= waitCycles - 1;
			end else begin
				base = held.lineAddr[addrWidth-1:2]; // word index of the line
				for (int w = 0; w < wordsPerLine; w++) begin
					if (held.write)
						mem[base + w] = held.line[w];
					else
						memRdata[w] <= mem[base + w];
				end
				if (held.write)
					storeCount <= storeCount + 1;
				memAck <= 1'b1;
				pending <= 1'b0;
			end
		end else if (memReq && !memAck) begin
			held <= memReqData;
			waitCycles <= 1 + ($unsigned($random(seed)) % 4);
			pending <= 1'b1;
		end else if (memAck && !memReq) begin
			memAck <= 1'b0;
		end
	end

endmodule
